/* common/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath and pc width
`define EXE_XLEN 32

// architectural register index
`define EXE_REG_AW 5

// operation word inside a micro-op, decoded per unit
`define EXE_OP_W 4

`endif

/* common/exe_pkg.sv */
`default_nettype none

`include "exe_macros.svh"

package exe_pkg;

    typedef enum logic [`EXE_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [`EXE_OP_W-1:0] {
        BR_JIRL,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_cond_t;

    typedef struct packed {
        logic                  high;
        logic                  sign;
        logic [`EXE_OP_W-3:0] pad;
    } mul_op_t;

    // op bits read differently per itype
    typedef union packed {
        alu_op_t  alu;
        br_cond_t br;
        mul_op_t  mul;
    } uop_op_u;

    typedef struct packed {
        logic alu;
        logic br;
        logic mul;
    } itype_t;

    typedef struct packed {
        itype_t  itype;
        logic    src2_imm;
        uop_op_u op;
    } uop_t;

    typedef struct packed {
        logic                    en;
        uop_t                    uop;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_REG_AW-1:0] rj;
        logic [`EXE_REG_AW-1:0] rk;
        logic [`EXE_XLEN-1:0]   imm;
        logic [`EXE_XLEN-1:0]   pc;
    } issue_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0] s0;
        logic [`EXE_XLEN-1:0] s1;
    } src_pair_t;

    typedef struct packed {
        logic                    en;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_XLEN-1:0]   data;
    } fwd_src_t;

    typedef struct packed {
        logic                    en;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_XLEN-1:0]   data;
        logic [`EXE_XLEN-1:0]   pc;
    } wb_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0] hh;
        logic [`EXE_XLEN-1:0] hl;
        logic [`EXE_XLEN-1:0] lh;
        logic [`EXE_XLEN-1:0] ll;
        logic [`EXE_XLEN-1:0] adj;
        logic                 high;
    } mul_part_t;

    typedef struct packed {
        logic                 valid;
        logic                 taken;
        logic [`EXE_XLEN-1:0] pc;
        logic [`EXE_XLEN-1:0] correct_pc_next;
    } br_resolve_t;

endpackage

`default_nettype wire

/* source/operand_forward.sv */
`default_nettype none

`include "exe_macros.svh"

module operand_forward
    import exe_pkg::*;
(
    input  issue_t    lane0,
    input  issue_t    lane1,
    input  src_pair_t rf0,
    input  src_pair_t rf1,
    input  fwd_src_t  mid0,
    input  fwd_src_t  mid1,
    input  fwd_src_t  out0,
    input  fwd_src_t  out1,
    output src_pair_t ops0,
    output src_pair_t ops1
);

    // newest producer wins with mid before out and lane 1 before lane 0
    function automatic logic [`EXE_XLEN-1:0] fwd_pick(
        input logic [`EXE_REG_AW-1:0] addr,
        input logic [`EXE_XLEN-1:0]   rf_val,
        input fwd_src_t               m0,
        input fwd_src_t               m1,
        input fwd_src_t               o0,
        input fwd_src_t               o1
    );
        if (addr == '0) begin
            return '0;
        end else if (m1.en && m1.rd == addr) begin
            return m1.data;
        end else if (m0.en && m0.rd == addr) begin
            return m0.data;
        end else if (o1.en && o1.rd == addr) begin
            return o1.data;
        end else if (o0.en && o0.rd == addr) begin
            return o0.data;
        end
        return rf_val;
    endfunction

    assign ops0 = '{
        s0: fwd_pick(lane0.rj, rf0.s0, mid0, mid1, out0, out1),
        s1: fwd_pick(lane0.rk, rf0.s1, mid0, mid1, out0, out1)
    };

    assign ops1 = '{
        s0: fwd_pick(lane1.rj, rf1.s0, mid0, mid1, out0, out1),
        s1: fwd_pick(lane1.rk, rf1.s1, mid0, mid1, out0, out1)
    };

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

`include "exe_macros.svh"

module alu
    import exe_pkg::*;
(
    input  alu_op_t              op,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    input  logic [`EXE_XLEN-1:0] imm,
    output logic [`EXE_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_NOR:  result = ~(a | b);
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            // immediate arrives already shifted into the upper bits
            ALU_LUI:  result = imm;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/branch_unit.sv */
`default_nettype none

`include "exe_macros.svh"

module branch_unit
    import exe_pkg::*;
(
    input  br_cond_t             cond,
    input  logic [`EXE_XLEN-1:0] pc,
    input  logic [`EXE_XLEN-1:0] pc_next,
    input  logic [`EXE_XLEN-1:0] imm,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output logic                 taken,
    output logic [`EXE_XLEN-1:0] target_next,
    output logic [`EXE_XLEN-1:0] link,
    output logic                 mispredict
);

    logic [`EXE_XLEN-1:0] seq_pc;
    logic [`EXE_XLEN-1:0] target;
    logic                 is_call;

    assign seq_pc = pc + 4;

    always_comb begin
        case (cond)
            BR_JIRL,
            BR_B,
            BR_BL:   taken = 1'b1;
            BR_BEQ:  taken = (a == b);
            BR_BNE:  taken = (a != b);
            BR_BLT:  taken = ($signed(a) < $signed(b));
            BR_BGE:  taken = ($signed(a) >= $signed(b));
            BR_BLTU: taken = (a < b);
            BR_BGEU: taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = (cond == BR_JIRL) ? a + imm : pc + imm;

    assign target_next = taken ? target : seq_pc;

    assign is_call = (cond == BR_BL) || (cond == BR_JIRL);

    // zero when nothing is linked, so the top can merge it
    assign link = is_call ? seq_pc : '0;

    assign mispredict = (target_next != pc_next);

endmodule

`default_nettype wire

/* mul/mul_partial.sv */
`default_nettype none

`include "exe_macros.svh"

module mul_partial
    import exe_pkg::*;
(
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    input  mul_op_t              op,
    output mul_part_t            parts
);

    localparam int HALF = `EXE_XLEN / 2;

    logic [`EXE_XLEN-1:0] a_hi;
    logic [`EXE_XLEN-1:0] a_lo;
    logic [`EXE_XLEN-1:0] b_hi;
    logic [`EXE_XLEN-1:0] b_lo;
    logic                 signed_hi;

    // zero-extended halves keep every product unsigned
    assign a_hi = {{HALF{1'b0}}, a[`EXE_XLEN-1:HALF]};
    assign a_lo = {{HALF{1'b0}}, a[HALF-1:0]};
    assign b_hi = {{HALF{1'b0}}, b[`EXE_XLEN-1:HALF]};
    assign b_lo = {{HALF{1'b0}}, b[HALF-1:0]};

    assign signed_hi = op.sign && op.high;

    assign parts.hh = a_hi * b_hi;
    assign parts.hl = a_hi * b_lo;
    assign parts.lh = a_lo * b_hi;
    assign parts.ll = a_lo * b_lo;

    // a negative operand adds 2^32 times the other one to the unsigned product
    assign parts.adj = ((signed_hi && a[`EXE_XLEN-1]) ? b : '0)
                     + ((signed_hi && b[`EXE_XLEN-1]) ? a : '0);

    assign parts.high = op.high;

endmodule

`default_nettype wire

/* mul/mul_combine.sv */
`default_nettype none

`include "exe_macros.svh"

module mul_combine
    import exe_pkg::*;
(
    input  mul_part_t            parts,
    output logic [`EXE_XLEN-1:0] result
);

    localparam int HALF = `EXE_XLEN / 2;

    logic [2*`EXE_XLEN-1:0] prod;
    logic [`EXE_XLEN-1:0]   upper;

    // hh and ll do not overlap, so they sit side by side
    assign prod = {parts.hh, parts.ll}
                + ({{`EXE_XLEN{1'b0}}, parts.hl} << HALF)
                + ({{`EXE_XLEN{1'b0}}, parts.lh} << HALF);

    // signed fixup only touches the upper word
    assign upper = prod[2*`EXE_XLEN-1:`EXE_XLEN] - parts.adj;

    assign result = parts.high ? upper : prod[`EXE_XLEN-1:0];

endmodule

`default_nettype wire

/* source/exe_stage.sv */
`default_nettype none

`include "exe_macros.svh"

module exe_stage
    import exe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  issue_t               lane0,
    input  issue_t               lane1,
    input  logic [`EXE_XLEN-1:0] lane0_pc_next,
    input  src_pair_t            rf0,
    input  src_pair_t            rf1,
    input  logic                 wb_flush,
    output wb_t                  wb0,
    output wb_t                  wb1,
    output br_resolve_t          br,
    output logic                 flush
);

    logic                 issue_ok;
    logic                 alu0_en;
    logic                 br_en;
    logic                 mul_en;
    logic                 alu1_en;
    logic                 link_en;
    src_pair_t            ops0;
    src_pair_t            ops1;
    fwd_src_t             mid0_src;
    fwd_src_t             mid1_src;
    fwd_src_t             out0_src;
    fwd_src_t             out1_src;
    logic [`EXE_XLEN-1:0] alu0_b;
    logic [`EXE_XLEN-1:0] alu1_b;
    logic [`EXE_XLEN-1:0] alu0_res;
    logic [`EXE_XLEN-1:0] alu1_res;
    logic [`EXE_XLEN-1:0] res0;
    logic                 br_taken;
    logic                 br_mispredict;
    logic [`EXE_XLEN-1:0] br_next;
    logic [`EXE_XLEN-1:0] br_link;
    mul_part_t            parts_d;
    mul_part_t            parts_q;
    logic [`EXE_XLEN-1:0] mul_res;
    wb_t                  mid0_q;
    wb_t                  mid1_q;
    logic                 mul_en_q;

    // bundle arriving right after a mispredict is on the wrong path
    assign issue_ok = !flush && !wb_flush;

    assign alu0_en = lane0.en && lane0.uop.itype.alu && issue_ok;
    assign br_en   = lane0.en && lane0.uop.itype.br && issue_ok;
    assign mul_en  = lane0.en && lane0.uop.itype.mul && issue_ok;
    assign alu1_en = lane1.en && lane1.uop.itype.alu && issue_ok;
    assign link_en = br_en && (lane0.uop.op.br == BR_BL || lane0.uop.op.br == BR_JIRL);

    assign alu0_b = lane0.uop.src2_imm ? lane0.imm : ops0.s1;
    assign alu1_b = lane1.uop.src2_imm ? lane1.imm : ops1.s1;

    assign mid0_src = '{en: mid0_q.en, rd: mid0_q.rd, data: mid0_q.data};
    assign mid1_src = '{en: mid1_q.en, rd: mid1_q.rd, data: mid1_q.data};
    assign out0_src = '{en: wb0.en, rd: wb0.rd, data: wb0.data};
    assign out1_src = '{en: wb1.en, rd: wb1.rd, data: wb1.data};

    operand_forward u_fwd (
        .lane0 (lane0),
        .lane1 (lane1),
        .rf0   (rf0),
        .rf1   (rf1),
        .mid0  (mid0_src),
        .mid1  (mid1_src),
        .out0  (out0_src),
        .out1  (out1_src),
        .ops0  (ops0),
        .ops1  (ops1)
    );

    alu u_alu0 (
        .op     (lane0.uop.op.alu),
        .a      (ops0.s0),
        .b      (alu0_b),
        .imm    (lane0.imm),
        .result (alu0_res)
    );

    alu u_alu1 (
        .op     (lane1.uop.op.alu),
        .a      (ops1.s0),
        .b      (alu1_b),
        .imm    (lane1.imm),
        .result (alu1_res)
    );

    branch_unit u_br (
        .cond        (lane0.uop.op.br),
        .pc          (lane0.pc),
        .pc_next     (lane0_pc_next),
        .imm         (lane0.imm),
        .a           (ops0.s0),
        .b           (ops0.s1),
        .taken       (br_taken),
        .target_next (br_next),
        .link        (br_link),
        .mispredict  (br_mispredict)
    );

    mul_partial u_mul0 (
        .a     (ops0.s0),
        .b     (ops0.s1),
        .op    (lane0.uop.op.mul),
        .parts (parts_d)
    );

    mul_combine u_mul1 (
        .parts  (parts_q),
        .result (mul_res)
    );

    // lane 0 mid data is zero unless an alu or link result is written
    assign res0 = alu0_en ? alu0_res : (link_en ? br_link : '0);

    always_ff @(posedge clk) begin
        parts_q <= parts_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid0_q   <= '0;
            mid1_q   <= '0;
            mul_en_q <= 1'b0;
            wb0      <= '0;
            wb1      <= '0;
            br       <= '0;
            flush    <= 1'b0;
        end else begin
            mid0_q   <= '{en: alu0_en || link_en, rd: lane0.rd, data: res0, pc: lane0.pc};
            mid1_q   <= '{en: alu1_en, rd: lane1.rd, data: alu1_res, pc: lane1.pc};
            mul_en_q <= mul_en;
            wb0 <= '{
                en:   (mid0_q.en || mul_en_q) && !wb_flush,
                rd:   mid0_q.rd,
                data: mid0_q.data | (mul_en_q ? mul_res : '0),
                pc:   mid0_q.pc
            };
            // partner of a mispredicted branch never writes back
            wb1 <= '{
                en:   mid1_q.en && !flush && !wb_flush,
                rd:   mid1_q.rd,
                data: mid1_q.data,
                pc:   mid1_q.pc
            };
            br    <= '{valid: br_en, taken: br_taken, pc: lane0.pc, correct_pc_next: br_next};
            flush <= br_en && br_mispredict;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_exe_stage.sv */
`default_nettype none

`include "exe_macros.svh"

module tb_exe_stage
    import exe_pkg::*;
;

    localparam int MAX_LINES = 64;

    // one lane of a stimulus line with every field padded to whole nibbles
    typedef struct packed {
        logic [3:0]  en;
        logic [3:0]  itype;
        logic [3:0]  src2;
        logic [3:0]  op;
        logic [7:0]  rd;
        logic [7:0]  rj;
        logic [7:0]  rk;
        logic [31:0] imm;
        logic [31:0] pc;
    } lane_f_t;

    typedef struct packed {
        logic [3:0]  en;
        logic [7:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } wb_f_t;

    typedef struct packed {
        logic [3:0]  valid;
        logic [3:0]  taken;
        logic [31:0] pc;
        logic [31:0] correct_pc_next;
    } br_f_t;

    typedef struct packed {
        lane_f_t     l0;
        lane_f_t     l1;
        logic [31:0] pc_next;
        logic [31:0] rf0_s0;
        logic [31:0] rf0_s1;
        logic [31:0] rf1_s0;
        logic [31:0] rf1_s1;
        logic [3:0]  wb_flush;
        logic [3:0]  chk;
        wb_f_t       e_wb0;
        wb_f_t       e_wb1;
        br_f_t       e_br;
        logic [3:0]  e_flush;
    } line_t;

    logic                 clk;
    logic                 rst_n;
    issue_t               lane0;
    issue_t               lane1;
    logic [`EXE_XLEN-1:0] lane0_pc_next;
    src_pair_t            rf0;
    src_pair_t            rf1;
    logic                 wb_flush;
    wb_t                  wb0;
    wb_t                  wb1;
    br_resolve_t          br;
    logic                 flush;

    logic [$bits(line_t)-1:0] stim_mem [0:MAX_LINES-1];
    line_t cur;
    int    n_lines;
    int    limit;
    int    cycles = 0;
    int    mismatches = 0;
    int    failures = 0;

    exe_stage dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .lane0         (lane0),
        .lane1         (lane1),
        .lane0_pc_next (lane0_pc_next),
        .rf0           (rf0),
        .rf1           (rf1),
        .wb_flush      (wb_flush),
        .wb0           (wb0),
        .wb1           (wb1),
        .br            (br),
        .flush         (flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic issue_t to_issue(input lane_f_t f);
        issue_t u;
        u.en             = f.en[0];
        u.uop.itype      = f.itype[2:0];
        u.uop.src2_imm   = f.src2[0];
        u.uop.op         = f.op;
        u.rd             = f.rd[4:0];
        u.rj             = f.rj[4:0];
        u.rk             = f.rk[4:0];
        u.imm            = f.imm;
        u.pc             = f.pc;
        return u;
    endfunction

    function automatic wb_t to_wb(input wb_f_t f);
        wb_t w;
        w.en   = f.en[0];
        w.rd   = f.rd[4:0];
        w.data = f.data;
        w.pc   = f.pc;
        return w;
    endfunction

    function automatic br_resolve_t to_br(input br_f_t f);
        br_resolve_t b;
        b.valid           = f.valid[0];
        b.taken           = f.taken[0];
        b.pc              = f.pc;
        b.correct_pc_next = f.correct_pc_next;
        return b;
    endfunction

    // payload only matters when the write is enabled
    task automatic check_wb(input string what, input wb_t got, input wb_t exp);
        if (got.en !== exp.en || (exp.en && (got.rd !== exp.rd || got.data !== exp.data
                                             || got.pc !== exp.pc))) begin
            $display(
                "Mismatch at %0t: %s en/rd/data/pc got %0b/%0d/%h/%h, exp %0b/%0d/%h/%h",
                $time, what, got.en, got.rd, got.data, got.pc,
                exp.en, exp.rd, exp.data, exp.pc);
            mismatches++;
        end
    endtask

    task automatic check_br(input br_resolve_t got, input br_resolve_t exp);
        if (got.valid !== exp.valid || (exp.valid && (got.taken !== exp.taken
                || got.pc !== exp.pc || got.correct_pc_next !== exp.correct_pc_next))) begin
            $display(
                "Mismatch at %0t: br valid/taken/pc/next got %0b/%0b/%h/%h, exp %0b/%0b/%h/%h",
                $time, got.valid, got.taken, got.pc, got.correct_pc_next,
                exp.valid, exp.taken, exp.pc, exp.correct_pc_next);
            mismatches++;
        end
    endtask

    task automatic check_flush(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: flush got %0b, expected %0b", $time, got, exp);
            mismatches++;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("run did not finish within %0d cycles, stopping", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        lane0         = '0;
        lane1         = '0;
        lane0_pc_next = '0;
        rf0           = '0;
        rf1           = '0;
        wb_flush      = 1'b0;
        for (int i = 0; i < MAX_LINES; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("tb/exe_stim.txt", stim_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim_mem[n_lines] != '0) begin
            n_lines++;
        end
        limit = n_lines + 20 + 3;
        if (n_lines == 0) begin
            $display("no stimulus lines could be loaded from tb/exe_stim.txt");
            failures++;
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            cur = stim_mem[i];
            lane0         <= to_issue(cur.l0);
            lane1         <= to_issue(cur.l1);
            lane0_pc_next <= cur.pc_next;
            rf0           <= '{s0: cur.rf0_s0, s1: cur.rf0_s1};
            rf1           <= '{s0: cur.rf1_s0, s1: cur.rf1_s1};
            wb_flush      <= cur.wb_flush[0];
            // outputs settle well before the falling edge
            @(negedge clk);
            if (cur.chk[0]) begin
                check_wb("wb0", wb0, to_wb(cur.e_wb0));
            end
            if (cur.chk[1]) begin
                check_wb("wb1", wb1, to_wb(cur.e_wb1));
            end
            if (cur.chk[2]) begin
                check_br(br, to_br(cur.e_br));
                check_flush(flush, cur.e_flush[0]);
            end
        end

        $display("lines=%0d mismatches=%0d other errors=%0d", n_lines, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/exe_stim.txt */
// lane0, lane1: en itype(alu4 br2 mul1) src2imm op _ rd rj rk _ imm _ pc | pc_next | rf0 s0 s1, rf1 s0 s1
// wb_flush chk | exp wb0, wb1: en rd data pc | exp br: valid taken pc next | exp flush
1400_010203_00000000_00001000_1410_040500_FFFFFFF6_00001004_00000000_00000005_00000007_00000064_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
1401_060104_00000000_00001008_1400_070000_00000000_0000100C_00000000_DEAD0001_DEAD0002_11111111_22222222_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
1407_080106_00000000_00001010_141B_080000_12345000_00001014_00000000_DEAD0003_DEAD0004_00000000_00000000_0_7_1_01_0000000C_00001000_1_04_0000005A_00001004_0_0_00000000_00000000_0
1400_090807_00000000_00001018_1414_010600_0000FFFF_0000101C_00000000_DEAD0005_DEAD0006_DEAD0007_00000000_0_7_1_06_FFFFFFB2_00001008_1_07_00000000_0000100C_0_0_00000000_00000000_0
1405_0A0801_00000000_00001020_141A_0B0C00_00000004_00001024_00000000_DEAD0008_DEAD0009_80000010_00000000_0_7_1_08_FFFFFFBE_00001010_1_08_12345000_00001014_0_0_00000000_00000000_0
1100_101112_00000000_00001028_1402_0D0E0F_00000000_0000102C_00000000_00012345_00006789_FFFFFFFF_00000001_0_7_1_09_12345000_00001018_1_01_0000FFB2_0000101C_0_0_00000000_00000000_0
110C_131415_00000000_00001030_1403_161718_00000000_00001034_00000000_80000000_7FFFFFFF_00000001_FFFFFFFF_0_7_1_0A_1234FFB2_00001020_1_0B_F8000001_00001024_0_0_00000000_00000000_0
1108_191A1B_00000000_00001038_0000_000000_00000000_00000000_00000000_80000000_7FFFFFFF_00000000_00000000_0_7_1_10_75CCA2ED_00001028_1_0D_00000001_0000102C_0_0_00000000_00000000_0
1203_001A1B_00000040_00002000_1410_1C0000_00000005_00002004_00002040_00000055_00000055_00000000_00000000_0_7_1_13_C0000000_00001030_1_16_00000001_00001034_0_0_00000000_00000000_0
1204_001D1E_00000100_00002040_0000_000000_00000000_00000000_00002044_00000001_00000001_00000000_00000000_0_7_1_19_3FFFFFFF_00001038_0_00_00000000_00000000_1_1_00002000_00002040_0
1202_010000_00001000_00002044_0000_000000_00000000_00000000_00003044_00000000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_1_1C_00000005_00002004_1_0_00002040_00002044_0
1200_1D1E00_00000010_00003044_0000_000000_00000000_00000000_00004010_00004000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_1_1_00002044_00003044_0
1200_050600_00000020_00004010_1410_070000_00000077_00004014_00004014_00005000_00000000_00000000_00000000_0_7_1_01_00002048_00002044_0_00_00000000_00000000_1_1_00003044_00004010_0
1410_080000_00000099_00004018_1410_090000_000000AA_0000401C_00000000_00000000_00000000_00000000_00000000_0_7_1_1D_00003048_00003044_0_00_00000000_00000000_1_1_00004010_00005020_1
1410_0A0000_00000123_00005020_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_1_05_00004014_00004010_0_00_00000000_00000000_0_0_00000000_00000000_0
0000_000000_00000000_00000000_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
1410_0B0000_00000011_00006000_1410_0C0000_00000022_00006004_00000000_00000000_00000000_00000000_00000000_0_7_1_0A_00000123_00005020_0_00_00000000_00000000_0_0_00000000_00000000_0
1410_0D0000_00000033_00006008_1410_0E0000_00000044_0000600C_00000000_00000000_00000000_00000000_00000000_1_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
0000_000000_00000000_00000000_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
1207_000102_00000040_00006010_0000_000000_00000000_00000000_00006014_FFFFFFFF_00000001_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
1410_0F0000_00000055_00007000_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_1_0_00006010_00006014_0
1205_000102_00000008_00007004_0000_000000_00000000_00000000_0000700C_FFFFFFFF_00000001_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0
0000_000000_00000000_00000000_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_1_0F_00000055_00007000_0_00_00000000_00000000_1_1_00007004_0000700C_0
0000_000000_00000000_00000000_0000_000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_0_7_0_00_00000000_00000000_0_00_00000000_00000000_0_0_00000000_00000000_0

/* sources.f */
+incdir+common
common/exe_pkg.sv
source/operand_forward.sv
source/alu.sv
source/branch_unit.sv
mul/mul_partial.sv
mul/mul_combine.sv
source/exe_stage.sv
tb/tb_exe_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the exe_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_exe_stage > build.log 2>&1 \
    && ./obj_dir/Vtb_exe_stage > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
